//--- dv/sdma_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdma_consts.svh"

module sdma_engine_tb;

    import sdma_pkg::*;

    // Worst case is 5 cycles per word plus pauses, with half again as margin
    localparam int TOTAL_WORDS = 128 + 384 + 1280 + 256 + 1152 + 40;
    localparam int MAX_CYCLES  = (TOTAL_WORDS * 5 + 400) * 3 / 2;

    logic                        clock;
    logic                        reset;
    sdma_cfg_t                   cfg;
    logic                        start;
    logic                        abort;
    sdma_irq_t                   irq_clear;
    sdma_irq_t                   irq;
    logic                        active;
    logic [`SDMA_FIFO_CNT_W-1:0] fifo_count;
    logic [`SDMA_DATA_W-1:0]     fifo_data;
    logic                        fifo_pop;
    wb_req_t                     wb;
    logic                        wb_ack;

    integer    seed        = 32'h2b2e;
    int        errors      = 0;
    int        checks      = 0;
    int        cycles      = 0;
    int        produced    = 0;
    int        popped      = 0;
    int        fill_div    = 1;
    int        fill_phase  = 0;
    int        ack_max     = 0;
    int        ack_wait    = 0;
    int        burst_words = 0;
    int        count_prev  = 0;
    logic      armed       = 1'b0;
    logic      flush_req   = 1'b0;
    logic      held_valid  = 1'b0;
    logic      cyc_prev    = 1'b0;
    logic      burst_cut   = 1'b0;
    logic      taken;
    wb_req_t   held;
    wb_req_t   writes[$];

    sdma_engine dut_i (
        .clock      (clock),
        .reset      (reset),
        .cfg        (cfg),
        .start      (start),
        .abort      (abort),
        .irq_clear  (irq_clear),
        .irq        (irq),
        .active     (active),
        .fifo_count (fifo_count),
        .fifo_data  (fifo_data),
        .fifo_pop   (fifo_pop),
        .wb         (wb),
        .wb_ack     (wb_ack)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the engine stopped making progress", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Head word of the FIFO for the nth word ever popped
    function automatic logic [`SDMA_DATA_W-1:0] word_value(input int n);
        return 32'h5d00_0000 + 32'(n);
    endfunction

    function automatic sdma_irq_t irq_val(input logic boundary, input logic complete);
        sdma_irq_t v;
        v.boundary = boundary;
        v.complete = complete;
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_wb(input wb_req_t got, input wb_req_t exp);
        checks++;
        if (got.adr !== exp.adr || got.dat !== exp.dat || got.we !== exp.we ||
            got.sel !== exp.sel) begin
            errors++;
            $display("mismatch at %0t: wb adr/dat/we/sel got %h/%h/%b/%h expected %h/%h/%b/%h",
                     $time, got.adr, got.dat, got.we, got.sel,
                     exp.adr, exp.dat, exp.we, exp.sel);
        end
    endtask

    task automatic check_irq(input sdma_irq_t got, input sdma_irq_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: irq {boundary,complete} got %b expected %b",
                     $time, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %0s got %b expected %b", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // FIFO and memory models, bus monitor
    //////////////////////////////////////////////////

    always @(posedge clock) begin
        // Values from just before the edge
        taken = wb.cyc && wb.stb && wb_ack;
        if (reset) begin
            check_bit("fifo_pop", fifo_pop, taken);
            if (held_valid) begin
                check_bit("wb.stb", wb.stb, 1'b1);
                check_wb(wb, held);
            end
            if (wb.cyc && !cyc_prev && count_prev < `SDMA_BURST_WORDS) begin
                errors++;
                $display("error at %0t: burst opened with only %0d words in the FIFO",
                         $time, count_prev);
            end
            if (!wb.cyc && cyc_prev && !burst_cut && burst_words != `SDMA_BURST_WORDS) begin
                errors++;
                $display("error at %0t: burst closed after %0d words instead of %0d",
                         $time, burst_words, `SDMA_BURST_WORDS);
            end
            if (!wb.cyc) begin
                burst_words = 0;
                burst_cut   = 1'b0;
            end
            if (taken) begin
                writes.push_back(wb);
                burst_words++;
            end
            // The FIFO drops its head word on each pop from the engine
            if (fifo_pop) popped++;
            if (abort && wb.cyc) burst_cut = 1'b1;
        end
        held_valid = wb.cyc && wb.stb && !wb_ack && !abort;
        held       = wb;
        cyc_prev   = wb.cyc;
        count_prev = int'(fifo_count);

        #1;
        if (flush_req) begin
            produced  = popped;
            flush_req = 1'b0;
        end
        if (fill_phase >= fill_div - 1) begin
            fill_phase = 0;
            if (produced - popped < 512) produced++;
        end else begin
            fill_phase++;
        end
        fifo_count = `SDMA_FIFO_CNT_W'(produced - popped);
        fifo_data  = word_value(popped);

        // Ack after a drawn delay, one word at a time
        if (taken) begin
            wb_ack = 1'b0;
            armed  = 1'b0;
        end
        if (wb.cyc && wb.stb) begin
            if (!armed && !wb_ack) begin
                ack_wait = $unsigned($random(seed)) % (ack_max + 1);
                armed    = 1'b1;
            end
            if (armed) begin
                if (ack_wait == 0) begin
                    wb_ack = 1'b1;
                    armed  = 1'b0;
                end else begin
                    ack_wait--;
                end
            end
        end else begin
            wb_ack = 1'b0;
            armed  = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Host side helpers
    //////////////////////////////////////////////////

    task automatic pulse_start();
        @(posedge clock);
        #1 start = 1'b1;
        @(posedge clock);
        #1 start = 1'b0;
    endtask

    task automatic start_transfer(input logic [`SDMA_ADDR_W-1:0] addr, input logic [2:0] code,
                                  input logic [`SDMA_BLKCNT_W-1:0] count);
        @(posedge clock);
        #1;
        cfg.sys_addr      = addr;
        cfg.boundary_code = code;
        cfg.block_count   = count;
        pulse_start();
    endtask

    task automatic resume_addr(input logic [`SDMA_ADDR_W-1:0] addr);
        @(posedge clock);
        #1;
        cfg.sys_addr       = addr;
        cfg.sys_addr_write = 1'b1;
        @(posedge clock);
        #1 cfg.sys_addr_write = 1'b0;
    endtask

    task automatic pulse_clear(input sdma_irq_t mask);
        @(posedge clock);
        #1 irq_clear = mask;
        @(posedge clock);
        #1 irq_clear = '0;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clock);
            #1;
        end while (active);
    endtask

    task automatic wait_boundary();
        do begin
            @(posedge clock);
            #1;
        end while (!irq.boundary && active);
    endtask

    // Recorded writes from index first on, at consecutive word addresses
    task automatic verify_writes(input int first, input int n,
                                 input logic [`SDMA_ADDR_W-1:0] addr);
        wb_req_t exp;
        int      i;
        if (writes.size() != first + n) begin
            errors++;
            $display("error at %0t: expected %0d writes in total but saw %0d",
                     $time, first + n, writes.size());
        end
        exp     = '0;
        exp.we  = 1'b1;
        exp.sel = '1;
        for (i = 0; i < n && first + i < writes.size(); i++) begin
            exp.adr = addr + 32'(`SDMA_ADDR_STEP * i);
            exp.dat = word_value(first + i);
            check_wb(writes[first + i], exp);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %0s done, %0d errors", name, errors - err0);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic one_block_test();
        int err0 = errors;
        int idx0 = writes.size();
        start_transfer(32'h1000_0000, 3'd0, 16'd1);
        check_bit("active", active, 1'b1);
        wait_idle();
        verify_writes(idx0, 128, 32'h1000_0000);
        check_irq(irq, irq_val(1'b0, 1'b1));
        check_bit("active", active, 1'b0);
        pulse_clear(irq_val(1'b0, 1'b1));
        report_test("one_block", err0);
    endtask

    task automatic starved_burst_test();
        int err0 = errors;
        int idx0 = writes.size();
        // Empty FIFO refilled one word every five cycles
        fill_div  = 5;
        flush_req = 1'b1;
        start_transfer(32'h2000_0400, 3'd0, 16'd3);
        check_bit("active", active, 1'b1);
        wait_idle();
        verify_writes(idx0, 384, 32'h2000_0400);
        check_irq(irq, irq_val(1'b0, 1'b1));
        pulse_clear(irq_val(1'b0, 1'b1));
        fill_div = 1;
        report_test("starved_burst", err0);
    endtask

    task automatic boundary_pause_test();
        int err0 = errors;
        int idx0 = writes.size();
        start_transfer(32'h3000_0000, 3'd0, 16'd10);
        check_bit("active", active, 1'b1);
        wait_boundary();
        check_irq(irq, irq_val(1'b1, 1'b0));
        check_bit("active", active, 1'b1);
        verify_writes(idx0, 1024, 32'h3000_0000);
        repeat (20) begin
            @(posedge clock);
            #1 check_bit("wb.cyc", wb.cyc, 1'b0);
        end
        pulse_clear(irq_val(1'b1, 1'b0));
        resume_addr(32'h3800_0000);
        wait_idle();
        verify_writes(idx0 + 1024, 256, 32'h3800_0000);
        check_irq(irq, irq_val(1'b0, 1'b1));
        pulse_clear(irq_val(1'b0, 1'b1));
        report_test("boundary_pause", err0);
    endtask

    task automatic ack_stall_test();
        int err0 = errors;
        int idx0 = writes.size();
        int pop0 = popped;
        ack_max = 3;
        start_transfer(32'h4000_0100, 3'd1, 16'd2);
        check_bit("active", active, 1'b1);
        wait_idle();
        verify_writes(idx0, 256, 32'h4000_0100);
        if (popped - pop0 != 256) begin
            errors++;
            $display("error at %0t: %0d words popped instead of 256", $time, popped - pop0);
        end
        check_irq(irq, irq_val(1'b0, 1'b1));
        pulse_clear(irq_val(1'b0, 1'b1));
        ack_max = 0;
        report_test("ack_stall", err0);
    endtask

    task automatic irq_clear_test();
        int err0 = errors;
        int idx0 = writes.size();
        start_transfer(32'h5000_0000, 3'd0, 16'd9);
        wait_boundary();
        // Start while paused must not restart the transfer
        pulse_start();
        repeat (20) begin
            @(posedge clock);
            #1 check_bit("wb.cyc", wb.cyc, 1'b0);
        end
        check_bit("active", active, 1'b1);
        check_irq(irq, irq_val(1'b1, 1'b0));
        resume_addr(32'h5800_0000);
        wait_idle();
        verify_writes(idx0 + 1024, 128, 32'h5800_0000);
        check_irq(irq, irq_val(1'b1, 1'b1));
        pulse_clear(irq_val(1'b1, 1'b0));
        check_irq(irq, irq_val(1'b0, 1'b1));
        pulse_clear(irq_val(1'b0, 1'b1));
        check_irq(irq, irq_val(1'b0, 1'b0));
        start_transfer(32'h5c00_0000, 3'd0, 16'd0);
        check_bit("active", active, 1'b0);
        report_test("irq_clear", err0);
    endtask

    task automatic abort_test();
        int err0 = errors;
        int idx0 = writes.size();
        int n_abort;
        start_transfer(32'h6000_0000, 3'd0, 16'd4);
        // Middle of the third burst
        do begin
            @(posedge clock);
            #1;
        end while (writes.size() < idx0 + 40);
        check_bit("wb.cyc", wb.cyc, 1'b1);
        abort = 1'b1;
        @(posedge clock);
        #1 abort = 1'b0;
        check_bit("wb.cyc", wb.cyc, 1'b0);
        check_bit("active", active, 1'b0);
        n_abort = writes.size();
        repeat (200) @(posedge clock);
        #1;
        if (writes.size() != n_abort) begin
            errors++;
            $display("error at %0t: %0d writes after the abort", $time, writes.size() - n_abort);
        end
        check_irq(irq, irq_val(1'b0, 1'b0));
        report_test("abort", err0);
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b0;
        cfg        = '0;
        start      = 1'b0;
        abort      = 1'b0;
        irq_clear  = '0;
        fifo_count = '0;
        fifo_data  = '0;
        wb_ack     = 1'b0;
        repeat (10) @(posedge clock);
        #1 reset = 1'b1;
        check_bit("active", active, 1'b0);
        check_irq(irq, irq_val(1'b0, 1'b0));
        one_block_test();
        starved_burst_test();
        boundary_pause_test();
        ack_stall_test();
        irq_clear_test();
        abort_test();
        $display("tests: 6, checks: %0d, errors: %0d, writes: %0d", checks, errors,
                 writes.size());
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/sdma_block_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdma_consts.svh"

module sdma_block_counter (
    input  wire                      clock,
    input  wire                      reset,
    input  wire [`SDMA_BLKCNT_W-1:0] block_count,
    input  wire                      block_done,
    input  wire                      count_clear,
    output logic                     last_block
);

    logic [`SDMA_BLKCNT_W-1:0] total_cnt;
    logic [`SDMA_BLKCNT_W-1:0] total_cnt_next;

    assign total_cnt_next = total_cnt + 1'b1;

    // Blocks of the whole transfer, across boundary pauses
    always_ff @(posedge clock) begin
        if (!reset) begin
            total_cnt  <= '0;
            last_block <= 1'b0;
        end else if (count_clear) begin
            total_cnt  <= '0;
            last_block <= 1'b0;
        end else if (block_done) begin
            total_cnt  <= total_cnt_next;
            last_block <= (total_cnt_next == block_count);
        end
    end

endmodule

`default_nettype wire

//--- hw/sdma_boundary_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdma_consts.svh"

module sdma_boundary_counter (
    input  wire       clock,
    input  wire       reset,
    input  wire [2:0] boundary_code,
    input  wire       block_done,
    input  wire       window_clear,
    output logic      window_full
);

    logic [`SDMA_BLKCNT_W-1:0] window_size;
    logic [`SDMA_BLKCNT_W-1:0] blk_cnt;
    logic [`SDMA_BLKCNT_W-1:0] blk_cnt_next;

    // 4 KB window at code 0, doubling per code step up to 512 KB
    assign window_size = `SDMA_BLKCNT_W'(`SDMA_BOUNDARY_BASE_BLOCKS) << boundary_code;

    assign blk_cnt_next = blk_cnt + 1'b1;

    always_ff @(posedge clock) begin
        if (!reset) begin
            blk_cnt     <= '0;
            window_full <= 1'b0;
        end else if (window_clear) begin
            blk_cnt     <= '0;
            window_full <= 1'b0;
        end else if (block_done) begin
            blk_cnt     <= blk_cnt_next;
            // Flag follows the count of the block just finished
            window_full <= (blk_cnt_next == window_size);
        end
    end

endmodule

`default_nettype wire

//--- hw/sdma_burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdma_consts.svh"

module sdma_burst_writer (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        block_go,
    input  wire                        load_addr,
    input  wire                        cancel,
    input  wire [`SDMA_ADDR_W-1:0]     start_addr,
    input  wire [`SDMA_FIFO_CNT_W-1:0] fifo_count,
    input  wire [`SDMA_DATA_W-1:0]     fifo_data,
    input  wire                        wb_ack,
    output sdma_pkg::wb_req_t          wb,
    output logic                       fifo_pop,
    output logic                       block_done
);

    localparam int WORD_CNT_W  = $clog2(`SDMA_BURST_WORDS);
    localparam int BURST_CNT_W = $clog2(`SDMA_BURSTS_PER_BLOCK);

    logic [`SDMA_ADDR_W-1:0] addr_q;
    logic [WORD_CNT_W-1:0]   word_cnt;
    logic [BURST_CNT_W-1:0]  burst_cnt;
    logic                    pending;
    logic                    cyc_q;
    logic                    block_done_q;

    logic                    word_taken;
    logic                    last_word;
    logic                    last_burst;
    logic                    burst_ready;

    // Word accepted by the slave in this cycle
    assign word_taken = cyc_q & wb_ack;

    assign last_word  = (word_cnt == WORD_CNT_W'(`SDMA_BURST_WORDS - 1));
    assign last_burst = (burst_cnt == BURST_CNT_W'(`SDMA_BURSTS_PER_BLOCK - 1));

    // Only open a burst when the whole burst is already buffered
    assign burst_ready = pending & ~cyc_q &
                         (fifo_count >= `SDMA_FIFO_CNT_W'(`SDMA_BURST_WORDS));

    //////////////////////////////////////////////////
    // Burst sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            cyc_q        <= 1'b0;
            pending      <= 1'b0;
            word_cnt     <= '0;
            burst_cnt    <= '0;
            block_done_q <= 1'b0;
        end else begin
            block_done_q <= 1'b0;
            if (cancel) begin
                cyc_q     <= 1'b0;
                pending   <= 1'b0;
                word_cnt  <= '0;
                burst_cnt <= '0;
            end else begin
                // New block from the controller
                if (block_go) begin
                    pending   <= 1'b1;
                    burst_cnt <= '0;
                end

                if (burst_ready) begin
                    cyc_q    <= 1'b1;
                    word_cnt <= '0;
                end else if (word_taken) begin
                    word_cnt <= word_cnt + 1'b1;
                    if (last_word) begin
                        // Bus idles at least one cycle between bursts
                        cyc_q    <= 1'b0;
                        word_cnt <= '0;
                        if (last_burst) begin
                            burst_cnt    <= '0;
                            pending      <= 1'b0;
                            block_done_q <= 1'b1;
                        end else begin
                            burst_cnt <= burst_cnt + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Running word address
    always_ff @(posedge clock) begin
        if (load_addr) begin
            addr_q <= start_addr;
        end else if (word_taken) begin
            addr_q <= addr_q + `SDMA_ADDR_W'(`SDMA_ADDR_STEP);
        end
    end

    //////////////////////////////////////////////////
    // Wishbone request
    //////////////////////////////////////////////////

    // Data comes straight from the FIFO head, it holds until the pop
    always_comb begin
        wb.cyc = cyc_q;
        wb.stb = cyc_q;
        wb.we  = 1'b1;
        wb.adr = addr_q;
        wb.dat = fifo_data;
        wb.sel = '1;
    end

    assign fifo_pop   = word_taken;
    assign block_done = block_done_q;

endmodule

`default_nettype wire

//--- hw/sdma_control.sv
`timescale 1ns/1ps
`default_nettype none

module sdma_control (
    input  wire                 clock,
    input  wire                 reset,
    input  sdma_pkg::sdma_cfg_t cfg,
    input  wire                 start,
    input  wire                 abort,
    input  sdma_pkg::sdma_irq_t irq_clear,
    input  wire                 block_done,
    input  wire                 window_full,
    input  wire                 last_block,
    output logic                block_go,
    output logic                load_addr,
    output logic                window_clear,
    output logic                count_clear,
    output logic                cancel,
    output sdma_pkg::sdma_irq_t irq,
    output logic                active
);

    import sdma_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MOVING,
        ST_CHECKING,
        ST_WAIT_ADDR
    } state_t;

    state_t    state;
    logic      block_go_q;
    logic      start_ok;
    logic      resume;
    sdma_irq_t irq_set;

    //////////////////////////////////////////////////
    // Host strobes
    //////////////////////////////////////////////////

    // Start only from idle, and never with nothing to move
    assign start_ok = start & ~abort & (state == ST_IDLE) & (cfg.block_count != '0);

    // New address after a boundary pause
    assign resume = (state == ST_WAIT_ADDR) & cfg.sys_addr_write & ~abort;

    // Address loads on the same edge, so it is ready one cycle after start
    assign load_addr    = start_ok | resume;
    assign window_clear = start_ok | resume;
    assign count_clear  = start_ok;
    assign cancel       = abort;

    // Completion wins over the boundary pause
    always_comb begin
        irq_set          = '0;
        irq_set.complete = (state == ST_CHECKING) & ~abort & last_block;
        irq_set.boundary = (state == ST_CHECKING) & ~abort & ~last_block & window_full;
    end

    //////////////////////////////////////////////////
    // Transfer FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= ST_IDLE;
            block_go_q <= 1'b0;
        end else begin
            block_go_q <= 1'b0;
            if (abort) begin
                state <= ST_IDLE;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (start_ok) begin
                            state      <= ST_MOVING;
                            block_go_q <= 1'b1;
                        end
                    end
                    ST_MOVING: begin
                        if (block_done) begin
                            state <= ST_CHECKING;
                        end
                    end
                    ST_CHECKING: begin
                        // Both counters settled on the block_done edge
                        if (last_block) begin
                            state <= ST_IDLE;
                        end else if (window_full) begin
                            state <= ST_WAIT_ADDR;
                        end else begin
                            state      <= ST_MOVING;
                            block_go_q <= 1'b1;
                        end
                    end
                    ST_WAIT_ADDR: begin
                        if (resume) begin
                            state      <= ST_MOVING;
                            block_go_q <= 1'b1;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // Sticky interrupt bits, a set beats a clear in the same cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            irq <= '0;
        end else begin
            irq.boundary <= irq_set.boundary | (irq.boundary & ~irq_clear.boundary);
            irq.complete <= irq_set.complete | (irq.complete & ~irq_clear.complete);
        end
    end

    assign block_go = block_go_q;
    assign active   = (state != ST_IDLE);

endmodule

`default_nettype wire

//--- hw/sdma_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdma_consts.svh"

module sdma_engine (
    input  wire                        clock,
    input  wire                        reset,
    // Host side
    input  sdma_pkg::sdma_cfg_t        cfg,
    input  wire                        start,
    input  wire                        abort,
    input  sdma_pkg::sdma_irq_t        irq_clear,
    output sdma_pkg::sdma_irq_t        irq,
    output logic                       active,
    // Receive FIFO
    input  wire [`SDMA_FIFO_CNT_W-1:0] fifo_count,
    input  wire [`SDMA_DATA_W-1:0]     fifo_data,
    output logic                       fifo_pop,
    // Wishbone master
    output sdma_pkg::wb_req_t          wb,
    input  wire                        wb_ack
);

    logic block_go;
    logic load_addr;
    logic window_clear;
    logic count_clear;
    logic cancel;
    logic block_done;
    logic window_full;
    logic last_block;

    //////////////////////////////////////////////////
    // Control and data path
    //////////////////////////////////////////////////

    sdma_control control_i (
        .clock        (clock),
        .reset        (reset),
        .cfg          (cfg),
        .start        (start),
        .abort        (abort),
        .irq_clear    (irq_clear),
        .block_done   (block_done),
        .window_full  (window_full),
        .last_block   (last_block),
        .block_go     (block_go),
        .load_addr    (load_addr),
        .window_clear (window_clear),
        .count_clear  (count_clear),
        .cancel       (cancel),
        .irq          (irq),
        .active       (active)
    );

    sdma_burst_writer burst_writer_i (
        .clock      (clock),
        .reset      (reset),
        .block_go   (block_go),
        .load_addr  (load_addr),
        .cancel     (cancel),
        .start_addr (cfg.sys_addr),
        .fifo_count (fifo_count),
        .fifo_data  (fifo_data),
        .wb_ack     (wb_ack),
        .wb         (wb),
        .fifo_pop   (fifo_pop),
        .block_done (block_done)
    );

    // Both counters see the same block_done edge
    sdma_boundary_counter boundary_counter_i (
        .clock         (clock),
        .reset         (reset),
        .boundary_code (cfg.boundary_code),
        .block_done    (block_done),
        .window_clear  (window_clear),
        .window_full   (window_full)
    );

    sdma_block_counter block_counter_i (
        .clock       (clock),
        .reset       (reset),
        .block_count (cfg.block_count),
        .block_done  (block_done),
        .count_clear (count_clear),
        .last_block  (last_block)
    );

endmodule

`default_nettype wire

//--- hw/sdma_pkg.sv
`default_nettype none

`include "sdma_consts.svh"

package sdma_pkg;

    //////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////

    // Transfer settings as programmed by the host
    typedef struct packed {
        logic [`SDMA_ADDR_W-1:0]   sys_addr;
        logic [2:0]                boundary_code;
        logic [`SDMA_BLKCNT_W-1:0] block_count;
        // New system address written, resumes after a boundary pause
        logic                      sys_addr_write;
    } sdma_cfg_t;

    // Interrupt status, same layout for the clear mask
    typedef struct packed {
        logic boundary;
        logic complete;
    } sdma_irq_t;

    //////////////////////////////////////////////////
    // Memory side
    //////////////////////////////////////////////////

    // Wishbone classic master request
    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`SDMA_ADDR_W-1:0]     adr;
        logic [`SDMA_DATA_W-1:0]     dat;
        logic [(`SDMA_DATA_W/8)-1:0] sel;
    } wb_req_t;

endpackage

`default_nettype wire

//--- include/sdma_consts.svh
`ifndef SDMA_CONSTS_SVH
`define SDMA_CONSTS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// System byte address
`define SDMA_ADDR_W 32

// Wishbone data word
`define SDMA_DATA_W 32

// Block count and both block counters
`define SDMA_BLKCNT_W 16

// FIFO word count, enough for a few blocks of buffering
`define SDMA_FIFO_CNT_W 10

//////////////////////////////////////////////////
// Transfer geometry
//////////////////////////////////////////////////

// Words per burst, also the FIFO level needed to open one
`define SDMA_BURST_WORDS 16

// 512-byte block as bursts
`define SDMA_BURSTS_PER_BLOCK 8

// Blocks per 4 KB window (boundary code 0), code n shifts left by n
`define SDMA_BOUNDARY_BASE_BLOCKS 8

// Byte step per word
`define SDMA_ADDR_STEP 4

`endif

//--- sdma_engine.f
+incdir+include
hw/sdma_pkg.sv
hw/sdma_burst_writer.sv
hw/sdma_boundary_counter.sv
hw/sdma_block_counter.sv
hw/sdma_control.sv
hw/sdma_engine.sv
dv/sdma_engine_tb.sv
